//--- fpu_misc_params.svh
/*
 * width and constant macros for the double-precision FPU misc unit
 * operand, exponent, fraction and tag widths
 * canonical quiet NaN pattern returned by fmin/fmax
 */

`ifndef FPU_MISC_PARAMS_SVH
`define FPU_MISC_PARAMS_SVH

// operand layout (IEEE 754 binary64)
`define FPU_XLEN 64
`define FPU_EXP_W 11
`define FPU_MANT_W 52

// request tag carried through the pipeline
`define FPU_TAG_W 4

// sign clear, exponent all ones, quiet bit set
`define FPU_CANON_NAN 64'h7ff8_0000_0000_0000

`endif

//--- fpu_misc_pkg.sv
/*
 * shared types for the FPU misc unit
 * operation enum, operand class, request, stage payload and response
 * plus the operand classify function used by the first stage
 */

`default_nettype none

`include "fpu_misc_params.svh"

package fpu_misc_pkg;

	typedef enum logic [3:0] {
		FSGNJ  = 4'd0,
		FSGNJN = 4'd1,
		FSGNJX = 4'd2,
		FCLASS = 4'd3,
		FEQ    = 4'd4,
		FLT    = 4'd5,
		FLE    = 4'd6,
		FMIN   = 4'd7,
		FMAX   = 4'd8
	} fpu_op_e;

	typedef struct packed {
		logic sign;
		logic is_zero;
		logic is_subnormal;
		logic is_inf;
		logic is_nan;
		logic is_snan;
	} fp_class_t;

	typedef struct packed {
		fpu_op_e                op;
		logic [`FPU_TAG_W-1:0] tag;
		logic [`FPU_XLEN-1:0]  opa;
		logic [`FPU_XLEN-1:0]  opb;
	} fpu_req_t;

	// request plus the decoded operand facts
	typedef struct packed {
		fpu_op_e                op;
		logic [`FPU_TAG_W-1:0] tag;
		logic [`FPU_XLEN-1:0]  opa;
		logic [`FPU_XLEN-1:0]  opb;
		fp_class_t              class_a;
		fp_class_t              class_b;
		logic                   mag_lt;
		logic                   mag_eq;
	} fpu_stage_t;

	typedef struct packed {
		logic [`FPU_TAG_W-1:0] tag;
		logic [`FPU_XLEN-1:0]  result;
		logic                   invalid;
	} fpu_resp_t;

	function automatic fp_class_t fp_classify(input logic [`FPU_XLEN-1:0] x);
		fp_class_t c;
		logic      exp_ones;
		logic      exp_zero;
		logic      frac_zero;
		exp_ones  = &x[`FPU_XLEN-2 -: `FPU_EXP_W];
		exp_zero  = ~|x[`FPU_XLEN-2 -: `FPU_EXP_W];
		frac_zero = ~|x[`FPU_MANT_W-1:0];
		c.sign         = x[`FPU_XLEN-1];
		c.is_zero      = exp_zero & frac_zero;
		c.is_subnormal = exp_zero & ~frac_zero;
		c.is_inf       = exp_ones & frac_zero;
		c.is_nan       = exp_ones & ~frac_zero;
		// signaling when the top fraction bit is clear
		c.is_snan      = c.is_nan & ~x[`FPU_MANT_W-1];
		return c;
	endfunction

endpackage

`default_nettype wire

//--- fpu_decode_stage.sv
/*
 * first pipeline stage of the FPU misc unit
 * registers the request with both operand classes
 * and the unsigned magnitude compare of opa and opb
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module fpu_decode_stage
	import fpu_misc_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             req_valid,
	input  wire fpu_req_t   req,
	output logic            s1_valid,
	output fpu_stage_t      s1
);

	////////////////////////////////////////////////////////////////////////////
	// operand decode
	////////////////////////////////////////////////////////////////////////////

	// magnitudes are exponent and fraction without the sign bit
	logic [`FPU_XLEN-2:0] mag_a;
	logic [`FPU_XLEN-2:0] mag_b;
	fpu_stage_t           s1_next;

	assign mag_a = req.opa[`FPU_XLEN-2:0];
	assign mag_b = req.opb[`FPU_XLEN-2:0];

	always_comb
	begin
		s1_next.op      = req.op;
		s1_next.tag     = req.tag;
		s1_next.opa     = req.opa;
		s1_next.opb     = req.opb;
		s1_next.class_a = fp_classify(req.opa);
		s1_next.class_b = fp_classify(req.opb);
		// biased exponent sits above the fraction so integer order is float order
		s1_next.mag_lt  = (mag_a < mag_b);
		s1_next.mag_eq  = (mag_a == mag_b);
	end

	////////////////////////////////////////////////////////////////////////////
	// stage register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= req_valid;
		end
	end

	// payload only moves with a valid request
	always_ff @(posedge clk)
	begin
		if (req_valid)
		begin
			s1 <= s1_next;
		end
	end

	// a signaling NaN is always also flagged as a NaN
	a_snan_is_nan: assert property (
		@(posedge clk) disable iff (rst)
		s1_valid |-> ((!s1.class_a.is_snan || s1.class_a.is_nan) &&
			(!s1.class_b.is_snan || s1.class_b.is_nan))
	)
	else $error("decode stage: snan class without nan class");

endmodule

`default_nettype wire

//--- fpu_compare_unit.sv
/*
 * combinational compare and min/max for the FPU misc unit
 * feq, flt, fle with 0/1 results and fmin, fmax with RISC-V NaN rules
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module fpu_compare_unit
	import fpu_misc_pkg::*;
(
	input  wire fpu_stage_t        s1,
	output logic [`FPU_XLEN-1:0]   cmp_result,
	output logic                   cmp_invalid
);

	logic any_nan;
	logic any_snan;
	logic both_zero;
	logic lt_total;
	logic lt_val;
	logic eq_val;

	assign any_nan   = s1.class_a.is_nan | s1.class_b.is_nan;
	assign any_snan  = s1.class_a.is_snan | s1.class_b.is_snan;
	assign both_zero = s1.class_a.is_zero & s1.class_b.is_zero;

	////////////////////////////////////////////////////////////////////////////
	// signed ordering
	////////////////////////////////////////////////////////////////////////////

	// total order with -0 below +0, used directly by fmin/fmax
	always_comb
	begin
		if (s1.class_a.sign != s1.class_b.sign)
			lt_total = s1.class_a.sign;
		else if (!s1.class_a.sign)
			lt_total = s1.mag_lt;
		else
			lt_total = !s1.mag_lt && !s1.mag_eq;
	end

	// IEEE compare treats the two zeros as equal
	assign lt_val = lt_total & ~both_zero & ~any_nan;
	assign eq_val = ((s1.mag_eq & (s1.class_a.sign == s1.class_b.sign)) | both_zero) & ~any_nan;

	////////////////////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cmp_result  = '0;
		cmp_invalid = 1'b0;
		case (s1.op)
			FEQ:
			begin
				cmp_result[0] = eq_val;
				// quiet compare only traps on signaling NaN
				cmp_invalid   = any_snan;
			end
			FLT:
			begin
				cmp_result[0] = lt_val;
				cmp_invalid   = any_nan;
			end
			FLE:
			begin
				cmp_result[0] = lt_val | eq_val;
				cmp_invalid   = any_nan;
			end
			FMIN, FMAX:
			begin
				if (s1.class_a.is_nan && s1.class_b.is_nan)
					cmp_result = `FPU_CANON_NAN;
				else if (s1.class_a.is_nan)
					cmp_result = s1.opb;
				else if (s1.class_b.is_nan)
					cmp_result = s1.opa;
				else if (lt_total ^ (s1.op == FMAX))
					cmp_result = s1.opa;
				else
					cmp_result = s1.opb;
				cmp_invalid = any_snan;
			end
			default:
			begin
				cmp_result  = '0;
				cmp_invalid = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- fpu_sign_class_unit.sv
/*
 * combinational sign injection and classify for the FPU misc unit
 * fsgnj, fsgnjn, fsgnjx and the ten-bit fclass mask
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module fpu_sign_class_unit
	import fpu_misc_pkg::*;
(
	input  wire fpu_stage_t        s1,
	output logic [`FPU_XLEN-1:0]   sc_result
);

	logic [9:0] class_mask;
	logic       is_normal;

	////////////////////////////////////////////////////////////////////////////
	// classify mask of opa
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		is_normal = !s1.class_a.is_zero && !s1.class_a.is_subnormal &&
			!s1.class_a.is_inf && !s1.class_a.is_nan;
		class_mask[0] = s1.class_a.sign & s1.class_a.is_inf;
		class_mask[1] = s1.class_a.sign & is_normal;
		class_mask[2] = s1.class_a.sign & s1.class_a.is_subnormal;
		class_mask[3] = s1.class_a.sign & s1.class_a.is_zero;
		class_mask[4] = ~s1.class_a.sign & s1.class_a.is_zero;
		class_mask[5] = ~s1.class_a.sign & s1.class_a.is_subnormal;
		class_mask[6] = ~s1.class_a.sign & is_normal;
		class_mask[7] = ~s1.class_a.sign & s1.class_a.is_inf;
		// NaN bits ignore the sign
		class_mask[8] = s1.class_a.is_snan;
		class_mask[9] = s1.class_a.is_nan & ~s1.class_a.is_snan;
		if (s1.op == FCLASS)
		begin
			a_class_onehot: assert ($onehot(class_mask))
			else $error("classify mask not one-hot: %b", class_mask);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// result select
	////////////////////////////////////////////////////////////////////////////

	// sign injection keeps opa's magnitude, NaN payload included
	always_comb
	begin
		case (s1.op)
			FSGNJ:
				sc_result = {s1.opb[`FPU_XLEN-1], s1.opa[`FPU_XLEN-2:0]};
			FSGNJN:
				sc_result = {~s1.opb[`FPU_XLEN-1], s1.opa[`FPU_XLEN-2:0]};
			FSGNJX:
				sc_result = {s1.opa[`FPU_XLEN-1] ^ s1.opb[`FPU_XLEN-1],
					s1.opa[`FPU_XLEN-2:0]};
			FCLASS:
				sc_result = {{(`FPU_XLEN-10){1'b0}}, class_mask};
			default:
				sc_result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- fpu_result_stage.sv
/*
 * second pipeline stage of the FPU misc unit
 * picks the compare or sign/class result and registers the response
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module fpu_result_stage
	import fpu_misc_pkg::*;
(
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       s1_valid,
	input  wire fpu_stage_t           s1,
	input  wire [`FPU_XLEN-1:0]       cmp_result,
	input  wire                       cmp_invalid,
	input  wire [`FPU_XLEN-1:0]       sc_result,
	output logic                      resp_valid,
	output fpu_resp_t                 resp
);

	logic      is_cmp_op;
	fpu_resp_t resp_next;

	////////////////////////////////////////////////////////////////////////////
	// result mux
	////////////////////////////////////////////////////////////////////////////

	// compare group owns the invalid flag
	assign is_cmp_op = (s1.op == FEQ) || (s1.op == FLT) || (s1.op == FLE) ||
		(s1.op == FMIN) || (s1.op == FMAX);

	always_comb
	begin
		resp_next.tag = s1.tag;
		if (is_cmp_op)
		begin
			resp_next.result  = cmp_result;
			resp_next.invalid = cmp_invalid;
		end
		else
		begin
			// sign injection and classify never raise a flag
			resp_next.result  = sc_result;
			resp_next.invalid = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// response register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			resp_valid <= 1'b0;
			resp       <= '0;
		end
		else
		begin
			resp_valid <= s1_valid;
			if (s1_valid)
				resp <= resp_next;
		end
	end

	a_resp_valid_known: assert property (
		@(posedge clk) disable iff (rst) !$isunknown(resp_valid)
	)
	else $error("resp_valid unknown after reset");

endmodule

`default_nettype wire

//--- fpu_misc_top.sv
/*
 * top level of the FPU misc unit
 * two-stage pipeline with compare and sign/class units between stages
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module fpu_misc_top
	import fpu_misc_pkg::*;
(
	input  wire           clk,
	input  wire           rst,
	input  wire           req_valid,
	input  wire fpu_req_t req,
	output logic          resp_valid,
	output fpu_resp_t     resp
);

	logic                 s1_valid;
	fpu_stage_t           s1;
	logic [`FPU_XLEN-1:0] cmp_result;
	logic                 cmp_invalid;
	logic [`FPU_XLEN-1:0] sc_result;

	fpu_decode_stage u_decode (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.s1_valid  (s1_valid),
		.s1        (s1)
	);

	// both units work on the stage one payload in parallel
	fpu_compare_unit u_compare (
		.s1          (s1),
		.cmp_result  (cmp_result),
		.cmp_invalid (cmp_invalid)
	);

	fpu_sign_class_unit u_sign_class (
		.s1        (s1),
		.sc_result (sc_result)
	);

	fpu_result_stage u_result (
		.clk         (clk),
		.rst         (rst),
		.s1_valid    (s1_valid),
		.s1          (s1),
		.cmp_result  (cmp_result),
		.cmp_invalid (cmp_invalid),
		.sc_result   (sc_result),
		.resp_valid  (resp_valid),
		.resp        (resp)
	);

endmodule

`default_nettype wire

//--- tb_fpu_misc.sv
/*
 * testbench for the FPU misc unit
 * directed table, seeded random stage checked against a behavioral model
 * pipelined response checking and a watchdog
 */

`timescale 1ns/1ps
`default_nettype none

`include "fpu_misc_params.svh"

module tb_fpu_misc
	import fpu_misc_pkg::*;
();

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES  = 3;
	localparam int DRAIN_CYCLES = 4;
	localparam int NUM_RAND     = 200;
	localparam int TABLE_MAX    = 64;

	// operand patterns
	localparam logic [63:0] PZERO = 64'h0000_0000_0000_0000;
	localparam logic [63:0] NZERO = 64'h8000_0000_0000_0000;
	localparam logic [63:0] ONE   = 64'h3ff0_0000_0000_0000;
	localparam logic [63:0] NONE  = 64'hbff0_0000_0000_0000;
	localparam logic [63:0] TWO   = 64'h4000_0000_0000_0000;
	localparam logic [63:0] NTWO  = 64'hc000_0000_0000_0000;
	localparam logic [63:0] PSUB  = 64'h0000_0000_0000_0001;
	localparam logic [63:0] NSUB  = 64'h8000_0000_0000_0001;
	localparam logic [63:0] PINF  = 64'h7ff0_0000_0000_0000;
	localparam logic [63:0] NINF  = 64'hfff0_0000_0000_0000;
	localparam logic [63:0] QNAN  = 64'h7ff8_0000_0000_0000;
	localparam logic [63:0] QNANP = 64'h7ff8_0000_0000_0abc;
	localparam logic [63:0] SNAN  = 64'h7ff0_0000_0000_0001;

	// one response waiting to come out of the pipeline
	typedef struct packed {
		logic [31:0]           due;
		logic [`FPU_TAG_W-1:0] tag;
		logic [`FPU_XLEN-1:0]  result;
		logic                  invalid;
	} expect_t;

	logic                  clk = 1'b0;
	logic                  rst;
	logic                  req_valid;
	fpu_req_t              req;
	logic                  resp_valid;
	fpu_resp_t             resp;
	integer                seed;
	int                    errors;
	int                    checks;
	logic [31:0]           cycle = 32'd0;
	logic [`FPU_TAG_W-1:0] tag_ctr;
	expect_t               exp_q[$];

	fpu_op_e     tbl_op  [TABLE_MAX];
	logic [63:0] tbl_a   [TABLE_MAX];
	logic [63:0] tbl_b   [TABLE_MAX];
	logic [63:0] tbl_res [TABLE_MAX];
	logic        tbl_inv [TABLE_MAX];
	int          tbl_count = 0;

	fpu_misc_top dut (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.resp_valid (resp_valid),
		.resp       (resp)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 32'd1;

	////////////////////////////////////////////////////////////////////////////
	// behavioral model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic is_nan_val(input logic [63:0] x);
		return (x[62:52] == 11'h7ff) && (x[51:0] != 52'h0);
	endfunction

	function automatic logic is_snan_val(input logic [63:0] x);
		return is_nan_val(x) && !x[51];
	endfunction

	// maps the float to an unsigned key whose order is the total order
	function automatic logic [63:0] order_key(input logic [63:0] x);
		return x[63] ? ~x : {1'b1, x[62:0]};
	endfunction

	function automatic logic [63:0] classify_mask(input logic [63:0] x);
		int idx;
		if (x[62:52] == 11'h7ff)
			idx = (x[51:0] == 52'h0) ? (x[63] ? 0 : 7) : (x[51] ? 9 : 8);
		else if (x[62:52] == 11'h000)
			idx = (x[51:0] == 52'h0) ? (x[63] ? 3 : 4) : (x[63] ? 2 : 5);
		else
			idx = x[63] ? 1 : 6;
		return 64'd1 << idx;
	endfunction

	// returns {invalid, result}
	function automatic logic [64:0] model_result(input fpu_op_e op,
		input logic [63:0] a, input logic [63:0] b);
		logic [63:0] res;
		logic        inv;
		logic        any_nan;
		logic        any_snan;
		logic        zeros;
		logic        a_less;
		any_nan  = is_nan_val(a) || is_nan_val(b);
		any_snan = is_snan_val(a) || is_snan_val(b);
		zeros    = (a[62:0] == 63'h0) && (b[62:0] == 63'h0);
		a_less   = order_key(a) < order_key(b);
		res      = 64'h0;
		inv      = 1'b0;
		case (op)
			FSGNJ:  res = {b[63], a[62:0]};
			FSGNJN: res = {~b[63], a[62:0]};
			FSGNJX: res = {a[63] ^ b[63], a[62:0]};
			FCLASS: res = classify_mask(a);
			FEQ:
			begin
				res[0] = !any_nan && (zeros || a == b);
				inv    = any_snan;
			end
			FLT:
			begin
				res[0] = !any_nan && !zeros && a_less;
				inv    = any_nan;
			end
			FLE:
			begin
				res[0] = !any_nan && (zeros || order_key(a) <= order_key(b));
				inv    = any_nan;
			end
			default:
			begin
				if (is_nan_val(a) && is_nan_val(b))
					res = `FPU_CANON_NAN;
				else if (is_nan_val(a))
					res = b;
				else if (is_nan_val(b))
					res = a;
				else if (op == FMIN)
					res = a_less ? a : b;
				else
					res = a_less ? b : a;
				inv = any_snan;
			end
		endcase
		return {inv, res};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stimulus table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_entry(input fpu_op_e op, input logic [63:0] a, input logic [63:0] b,
		input logic [63:0] res, input logic inv);
		tbl_op[tbl_count]  = op;
		tbl_a[tbl_count]   = a;
		tbl_b[tbl_count]   = b;
		tbl_res[tbl_count] = res;
		tbl_inv[tbl_count] = inv;
		tbl_count++;
	endtask

	task automatic load_table();
		// sign injection, NaN and infinity magnitudes kept
		add_entry(FSGNJ, ONE, NTWO, NONE, 1'b0);
		add_entry(FSGNJN, ONE, NTWO, ONE, 1'b0);
		add_entry(FSGNJX, NONE, NTWO, ONE, 1'b0);
		add_entry(FSGNJ, SNAN, NZERO, 64'hfff0_0000_0000_0001, 1'b0);
		add_entry(FSGNJN, NINF, PZERO, NINF, 1'b0);
		add_entry(FSGNJX, QNANP, NONE, 64'hfff8_0000_0000_0abc, 1'b0);
		// one entry per classify category
		add_entry(FCLASS, NINF, PZERO, 64'h001, 1'b0);
		add_entry(FCLASS, NONE, PZERO, 64'h002, 1'b0);
		add_entry(FCLASS, NSUB, PZERO, 64'h004, 1'b0);
		add_entry(FCLASS, NZERO, PZERO, 64'h008, 1'b0);
		add_entry(FCLASS, PZERO, PZERO, 64'h010, 1'b0);
		add_entry(FCLASS, PSUB, PZERO, 64'h020, 1'b0);
		add_entry(FCLASS, ONE, PZERO, 64'h040, 1'b0);
		add_entry(FCLASS, PINF, PZERO, 64'h080, 1'b0);
		add_entry(FCLASS, SNAN, PZERO, 64'h100, 1'b0);
		add_entry(FCLASS, QNAN, PZERO, 64'h200, 1'b0);
		// compares
		add_entry(FEQ, PZERO, NZERO, 64'h1, 1'b0);
		add_entry(FEQ, ONE, TWO, 64'h0, 1'b0);
		add_entry(FEQ, QNAN, ONE, 64'h0, 1'b0);
		add_entry(FEQ, SNAN, ONE, 64'h0, 1'b1);
		add_entry(FLT, NONE, ONE, 64'h1, 1'b0);
		add_entry(FLT, NZERO, PZERO, 64'h0, 1'b0);
		add_entry(FLT, NTWO, NONE, 64'h1, 1'b0);
		add_entry(FLT, QNAN, ONE, 64'h0, 1'b1);
		add_entry(FLE, PZERO, NZERO, 64'h1, 1'b0);
		add_entry(FLE, TWO, ONE, 64'h0, 1'b0);
		add_entry(FLE, ONE, SNAN, 64'h0, 1'b1);
		// min and max
		add_entry(FMIN, ONE, TWO, ONE, 1'b0);
		add_entry(FMAX, ONE, TWO, TWO, 1'b0);
		add_entry(FMIN, PZERO, NZERO, NZERO, 1'b0);
		add_entry(FMAX, NZERO, PZERO, PZERO, 1'b0);
		add_entry(FMIN, QNAN, TWO, TWO, 1'b0);
		add_entry(FMAX, NONE, QNANP, NONE, 1'b0);
		add_entry(FMIN, SNAN, ONE, ONE, 1'b1);
		add_entry(FMAX, QNAN, SNAN, `FPU_CANON_NAN, 1'b1);
		add_entry(FMIN, QNANP, QNANP, `FPU_CANON_NAN, 1'b0);
		add_entry(FMAX, NINF, NTWO, NTWO, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drive and check
	////////////////////////////////////////////////////////////////////////////

	// category picked first so every class shows up often
	function automatic logic [63:0] random_operand();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		r0 = $random(seed);
		r1 = $random(seed);
		r2 = $random(seed);
		case (r0[2:0])
			3'd2: return {r0[3], 63'h0};
			3'd3: return {r0[3], 11'h7ff, 52'h0};
			3'd4: return {r0[3], 11'h7ff, 1'b1, r1[18:0], r2};
			3'd5: return {r0[3], 11'h7ff, 1'b0, r1[18:0], r2[31:1], 1'b1};
			3'd6: return {r0[3], 11'h000, r1[19:0], r2[31:1], 1'b1};
			3'd7: return {r0[3], 11'h3ff, r1[19:0], r2};
			default: return {r1, r2};
		endcase
	endfunction

	task automatic send_request(input fpu_op_e op, input logic [63:0] a,
		input logic [63:0] b, input logic [63:0] res, input logic inv);
		expect_t e;
		req_valid = 1'b1;
		req.op    = op;
		req.tag   = tag_ctr;
		req.opa   = a;
		req.opb   = b;
		// sampled at the next rising edge, out one edge after that
		e.due     = cycle + 32'd2;
		e.tag     = tag_ctr;
		e.result  = res;
		e.invalid = inv;
		exp_q.push_back(e);
		tag_ctr   = tag_ctr + 1'b1;
	endtask

	task automatic check_outputs();
		expect_t e;
		checks++;
		if (resp_valid)
		begin
			assert (exp_q.size() > 0)
			else
			begin
				errors++;
				$display("Error: time %0t resp_valid expected 0 actual 1", $time);
			end
			if (exp_q.size() > 0)
			begin
				e = exp_q.pop_front();
				assert (e.due == cycle)
				else
				begin
					errors++;
					$display("Error: response for tag %0d came in cycle %0d, not cycle %0d",
						e.tag, cycle, e.due);
				end
				assert (resp.tag == e.tag)
				else
				begin
					errors++;
					$display("Error: time %0t resp.tag expected %0d actual %0d",
						$time, e.tag, resp.tag);
				end
				assert (resp.result == e.result)
				else
				begin
					errors++;
					$display("Error: time %0t resp.result expected %h actual %h",
						$time, e.result, resp.result);
				end
				assert (resp.invalid == e.invalid)
				else
				begin
					errors++;
					$display("Error: time %0t resp.invalid expected %b actual %b",
						$time, e.invalid, resp.invalid);
				end
			end
		end
		else if (exp_q.size() > 0)
		begin
			assert (exp_q[0].due > cycle)
			else
			begin
				errors++;
				$display("Error: time %0t resp_valid expected 1 actual 0", $time);
				e = exp_q.pop_front();
			end
		end
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		check_outputs();
		req_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : main_seq
		logic [31:0] r;
		logic [31:0] op_idx;
		logic [63:0] a;
		logic [63:0] b;
		logic [64:0] m;
		fpu_op_e     op;
		seed      = 46;
		errors    = 0;
		checks    = 0;
		tag_ctr   = '0;
		rst       = 1'b1;
		req_valid = 1'b0;
		req       = '0;
		load_table();
		repeat (RESET_CYCLES)
			idle_cycle();
		rst = 1'b0;
		for (int i = 0; i < tbl_count; i++)
		begin
			@(negedge clk);
			check_outputs();
			send_request(tbl_op[i], tbl_a[i], tbl_b[i], tbl_res[i], tbl_inv[i]);
		end
		repeat (IDLE_CYCLES)
			idle_cycle();
		for (int i = 0; i < NUM_RAND; i++)
		begin
			r      = $random(seed);
			op_idx = r % 32'd9;
			op     = fpu_op_e'(op_idx[3:0]);
			a      = random_operand();
			// equal and sign-flipped pairs exercise the zero and tie rules
			case (r[9:8])
				2'd0:    b = a;
				2'd1:    b = {~a[63], a[62:0]};
				default: b = random_operand();
			endcase
			m = model_result(op, a, b);
			@(negedge clk);
			check_outputs();
			send_request(op, a, b, m[63:0], m[64]);
		end
		repeat (DRAIN_CYCLES)
			idle_cycle();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin : watchdog
		int limit_cycles;
		#1;
		limit_cycles = tbl_count + NUM_RAND + RESET_CYCLES + IDLE_CYCLES + DRAIN_CYCLES + 20;
		#(limit_cycles * CLK_PERIOD);
		$display("Error: watchdog timeout, run did not end within %0d cycles", limit_cycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
fpu_misc_pkg.sv
fpu_decode_stage.sv
fpu_compare_unit.sv
fpu_sign_class_unit.sv
fpu_result_stage.sv
fpu_misc_top.sv
tb_fpu_misc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the FPU misc testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f project.f --top-module tb_fpu_misc \
	--Mdir obj_dir -o sim_fpu_misc

./obj_dir/sim_fpu_misc | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"
exit 0
